//--- rfir_top.f
design/rfir_pkg.sv
design/rfir_ctrl.sv
design/coeff_bank.sv
design/sample_delay_line.sv
design/tap_multiplier.sv
design/output_adder_tree.sv
design/rfir_top.sv
verification/rfir_top_tb.sv

//--- Makefile
TOP := rfir_top_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f rfir_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/rfir_top_tb.sv
`timescale 1ns/1ps

module rfir_top_tb;
    import rfir_pkg::*;

    localparam int CLK_HALF       = 50;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PIPE_DEPTH     = 8;
    localparam int LOAD_CYCLES    = 49;
    localparam int RAM_WORDS      = 1 << ADDR_W;

    logic              clk;
    logic              reset;
    logic              en_rfir;
    rfir_mode_t        mode_rfir;
    sample_t           in;
    sample_t           ram_coeff;
    sample_t           out;
    logic [ADDR_W-1:0] addr_out;

    sample_t           ram [RAM_WORDS];
    logic [ADDR_W-1:0] ram_addr_q;

    // Reference model state
    sample_t    hist [MAX_TAPS];
    sample_t    coef_m [MAX_TAPS];
    sample_t    filt_q [$];
    sample_t    exp_out;
    sample_t    in_d;
    logic       en_d;
    rfir_mode_t prev_mode_m;
    logic       first_m;
    logic       rdy_m;
    int         load_pos;

    int err_count;
    int err_base;
    int tests_passed;
    int tests_failed;
    int cycle_count;

    rfir_top rfir_top_i (
        .clk       (clk),
        .reset     (reset),
        .en_rfir   (en_rfir),
        .mode_rfir (mode_rfir),
        .in        (in),
        .ram_coeff (ram_coeff),
        .out       (out),
        .addr_out  (addr_out)
    );

    always #(CLK_HALF) clk = ~clk;

    ////////////////////////////////////////
    // Coefficient RAM, one cycle read latency
    ////////////////////////////////////////
    always @(negedge clk) begin
        ram_addr_q = addr_out;
    end

    always @(posedge clk) begin
        #1;
        ram_coeff = ram[ram_addr_q];
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic int taps_for(rfir_mode_t m);
        case (m)
            MODE_TAP24: return TAPS_SHORT;
            MODE_TAP48: return MAX_TAPS;
            default:    return 0;
        endcase
    endfunction

    // Cycles since the current load began, -1 when idle
    function automatic int load_pos_now();
        if (first_m || (mode_rfir != prev_mode_m)) begin
            return 0;
        end
        return load_pos;
    endfunction

    function automatic sample_t scaled_sum();
        longint acc;
        acc = 0;
        for (int k = 0; k < MAX_TAPS; k++) begin
            acc += longint'(coef_m[k]) * longint'(hist[k]);
        end
        return acc[31:16];
    endfunction

    always @(posedge clk) begin : ref_model
        int      pos;
        logic    restart;
        sample_t filt;
        if (reset) begin
            for (int k = 0; k < MAX_TAPS; k++) begin
                hist[k]   = '0;
                coef_m[k] = '0;
            end
            filt_q.delete();
            repeat (PIPE_DEPTH - 1) filt_q.push_back(sample_t'(0));
            exp_out     = '0;
            in_d        = '0;
            en_d        = 1'b0;
            prev_mode_m = MODE_OFF;
            first_m     = 1'b1;
            rdy_m       = 1'b0;
            load_pos    = -1;
        end else begin
            restart = first_m || (mode_rfir != prev_mode_m);
            pos     = load_pos_now();
            for (int k = MAX_TAPS - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0] = in;
            // Products are zero until the taps are loaded
            filt_q.push_back(rdy_m ? scaled_sum() : sample_t'(0));
            filt    = filt_q.pop_front();
            exp_out = en_rfir ? filt : in;
            en_d    = en_rfir;
            in_d    = in;
            if (restart) begin
                rdy_m = 1'b0;
            end
            // 48 writes done, taps usable next cycle
            if (pos == MAX_TAPS) begin
                rdy_m = 1'b1;
                for (int k = 0; k < MAX_TAPS; k++) begin
                    coef_m[k] = (k < taps_for(mode_rfir)) ? ram[k] : sample_t'(0);
                end
                load_pos = -1;
            end else if (pos >= 0) begin
                load_pos = pos + 1;
            end
            prev_mode_m = mode_rfir;
            first_m     = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    always @(negedge clk) begin : output_checks
        int pos;
        int exp_addr;
        if (!reset) begin
            pos      = load_pos_now();
            exp_addr = (pos >= 0 && pos < taps_for(mode_rfir)) ? pos : 0;
            out_matches: assert (out == exp_out) else begin
                $display("ERR out: got %h expected %h", out, exp_out);
                err_count++;
            end
            addr_matches: assert (addr_out == ADDR_W'(exp_addr)) else begin
                $display("ERR addr_out: got %h expected %h", addr_out, ADDR_W'(exp_addr));
                err_count++;
            end
        end
    end

    bypass_follows_in: assert property (
        @(negedge clk) disable iff (reset) !en_d |-> out == in_d
    ) else begin
        $display("ERR out: got %h expected %h in bypass", out, in_d);
        err_count++;
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) next_cycle();
        reset = 1'b0;
    endtask

    task automatic drive_random(int n);
        repeat (n) begin
            in = sample_t'($urandom);
            next_cycle();
        end
    endtask

    task automatic fill_ram_random();
        for (int a = 0; a < MAX_TAPS; a++) begin
            ram[a] = sample_t'($urandom);
        end
    endtask

    task automatic start_test();
        err_base = err_count;
    endtask

    task automatic finish_test(string name);
        if (err_count == err_base) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_count - err_base);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic bypass_random_inputs();
        start_test();
        en_rfir = 1'b0;
        drive_random(40);
        finish_test("bypass");
    endtask

    task automatic load_and_check_addr(rfir_mode_t m);
        int n;
        n         = taps_for(m);
        mode_rfir = m;
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            addr_steps: assert (addr_out == ADDR_W'(k)) else begin
                $display("ERR addr_out: got %h expected %h", addr_out, ADDR_W'(k));
                err_count++;
            end
            next_cycle();
        end
        repeat (LOAD_CYCLES - n) next_cycle();
    endtask

    task automatic address_sequence();
        start_test();
        load_and_check_addr(MODE_TAP24);
        load_and_check_addr(MODE_TAP48);
        finish_test("load addressing");
    endtask

    task automatic impulse_response_24();
        longint  prod;
        sample_t expect_val;
        start_test();
        en_rfir   = 1'b1;
        in        = '0;
        mode_rfir = MODE_TAP24;
        // Load and flush the delay line with zeros
        repeat (LOAD_CYCLES + PIPE_DEPTH) next_cycle();
        in = 16'sh7FFF;
        next_cycle();
        in = '0;
        for (int d = 1; d < MAX_TAPS + PIPE_DEPTH; d++) begin
            @(negedge clk);
            if (d >= PIPE_DEPTH) begin
                if (d - PIPE_DEPTH < TAPS_SHORT) begin
                    prod = longint'(ram[d-PIPE_DEPTH]) * 32767;
                end else begin
                    prod = 0;
                end
                expect_val = prod[31:16];
                impulse_tap: assert (out == expect_val) else begin
                    $display("ERR out: got %h expected %h", out, expect_val);
                    err_count++;
                end
            end
            next_cycle();
        end
        finish_test("impulse response, 24 taps");
    endtask

    task automatic random_stream_48();
        start_test();
        fill_ram_random();
        mode_rfir = MODE_TAP48;
        en_rfir   = 1'b1;
        drive_random(LOAD_CYCLES + PIPE_DEPTH + 200);
        finish_test("random samples, 48 taps");
    endtask

    task automatic mode_switch_reload();
        start_test();
        drive_random(60);
        fill_ram_random();
        mode_rfir = MODE_TAP24;
        drive_random(LOAD_CYCLES + PIPE_DEPTH + 60);
        // Unused mode loads all zero taps
        mode_rfir = MODE_UNUSED;
        drive_random(LOAD_CYCLES + PIPE_DEPTH + 20);
        finish_test("mode change reload");
    endtask

    task automatic state_after_reset();
        start_test();
        en_rfir   = 1'b0;
        mode_rfir = MODE_TAP48;
        drive_random(20);
        apply_reset();
        @(negedge clk);
        out_after_reset: assert (out == '0) else begin
            $display("ERR out: got %h expected %h", out, 16'h0);
            err_count++;
        end
        addr_after_reset: assert (addr_out == '0) else begin
            $display("ERR addr_out: got %h expected %h", addr_out, 7'h0);
            err_count++;
        end
        next_cycle();
        finish_test("reset state");
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        en_rfir      = 1'b0;
        mode_rfir    = MODE_OFF;
        in           = '0;
        ram_coeff    = '0;
        ram_addr_q   = '0;
        err_count    = 0;
        err_base     = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        void'($urandom(69));
        for (int a = 0; a < RAM_WORDS; a++) begin
            ram[a] = sample_t'({7'(a), ~7'(a), 2'b01});
        end

        apply_reset();
        bypass_random_inputs();
        address_sequence();
        impulse_response_24();
        random_stream_48();
        mode_switch_reload();
        state_after_reset();

        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- design/rfir_top.sv
`timescale 1ns/1ps

module rfir_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        en_rfir,
    input  rfir_pkg::rfir_mode_t        mode_rfir,
    input  rfir_pkg::sample_t           in,
    input  rfir_pkg::sample_t           ram_coeff,
    output rfir_pkg::sample_t           out,
    output logic [rfir_pkg::ADDR_W-1:0] addr_out
);
    import rfir_pkg::*;

    coeff_wr_t   coeff_wr;
    logic        coeff_rdy;
    coeff_vec_t  coeffs;
    sample_vec_t taps;
    prod_vec_t   prods;

    ////////////////////////////////////////
    // Coefficient load path
    ////////////////////////////////////////
    rfir_ctrl rfir_ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .mode_rfir (mode_rfir),
        .ram_coeff (ram_coeff),
        .addr_out  (addr_out),
        .coeff_wr  (coeff_wr),
        .coeff_rdy (coeff_rdy)
    );

    coeff_bank coeff_bank_i (
        .clk      (clk),
        .reset    (reset),
        .coeff_wr (coeff_wr),
        .coeffs   (coeffs)
    );

    ////////////////////////////////////////
    // Sample datapath
    ////////////////////////////////////////
    sample_delay_line sample_delay_line_i (
        .clk   (clk),
        .reset (reset),
        .in    (in),
        .taps  (taps)
    );

    tap_multiplier tap_multiplier_i (
        .clk       (clk),
        .reset     (reset),
        .coeffs    (coeffs),
        .taps      (taps),
        .coeff_rdy (coeff_rdy),
        .prods     (prods)
    );

    // Bypass mux lives in the last tree stage
    output_adder_tree output_adder_tree_i (
        .clk     (clk),
        .reset   (reset),
        .prods   (prods),
        .en_rfir (en_rfir),
        .in      (in),
        .out     (out)
    );

endmodule

//--- design/output_adder_tree.sv
`timescale 1ns/1ps

module output_adder_tree (
    input  logic                clk,
    input  logic                reset,
    input  rfir_pkg::prod_vec_t prods,
    input  logic                en_rfir,
    input  rfir_pkg::sample_t   in,
    output rfir_pkg::sample_t   out
);
    import rfir_pkg::*;

    typedef logic signed [SUM_W-1:0] sum_t;

    prod_vec_t prods_q;
    sum_t      leaf [TREE_LEAVES];
    // Heap order, node i adds nodes 2i and 2i+1
    sum_t      node [2:TREE_LEAVES-1];
    sum_t      total;

    ////////////////////////////////////////
    // Leaves, zero padded to a power of two
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < TREE_LEAVES; i++) begin
            leaf[i] = '0;
        end
        for (int i = 0; i < MAX_TAPS; i++) begin
            leaf[i] = sum_t'(prods_q[i]);
        end
    end

    ////////////////////////////////////////
    // Levels 1 to 5
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            prods_q <= '0;
            for (int i = 2; i < TREE_LEAVES; i++) begin
                node[i] <= '0;
            end
        end else begin
            prods_q <= prods;
            // Level 1 straight from the leaves
            for (int i = TREE_LEAVES / 2; i < TREE_LEAVES; i++) begin
                node[i] <= leaf[2*i-TREE_LEAVES] + leaf[2*i-TREE_LEAVES+1];
            end
            for (int i = 2; i < TREE_LEAVES / 2; i++) begin
                node[i] <= node[2*i] + node[2*i+1];
            end
        end
    end

    ////////////////////////////////////////
    // Level 6 and output select
    ////////////////////////////////////////
    assign total = node[2] + node[3];

    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else if (!en_rfir) begin
            out <= in;
        end else begin
            // Scaled once on the full sum
            out <= total[OUT_SHIFT +: SAMPLE_W];
        end
    end

endmodule

//--- design/tap_multiplier.sv
`timescale 1ns/1ps

module tap_multiplier (
    input  logic                  clk,
    input  logic                  reset,
    input  rfir_pkg::coeff_vec_t  coeffs,
    input  rfir_pkg::sample_vec_t taps,
    input  logic                  coeff_rdy,
    output rfir_pkg::prod_vec_t   prods
);
    import rfir_pkg::*;

    prod_vec_t prods_next;

    always_comb begin
        for (int k = 0; k < MAX_TAPS; k++) begin
            prods_next[k] = coeffs[k] * taps[k];
        end
    end

    // Products held at zero while a load is in progress
    always_ff @(posedge clk) begin
        if (reset || !coeff_rdy) begin
            prods <= '0;
        end else begin
            prods <= prods_next;
        end
    end

endmodule

//--- design/sample_delay_line.sv
`timescale 1ns/1ps

module sample_delay_line (
    input  logic                  clk,
    input  logic                  reset,
    input  rfir_pkg::sample_t     in,
    output rfir_pkg::sample_vec_t taps
);
    import rfir_pkg::*;

    // Stage k holds the input from k cycles back
    sample_t [MAX_TAPS-1:1] stages;

    always_ff @(posedge clk) begin
        if (reset) begin
            stages <= '0;
        end else begin
            stages <= {stages[MAX_TAPS-2:1], in};
        end
    end

    // Live sample sits at tap 0
    assign taps = {stages, in};

endmodule

//--- design/coeff_bank.sv
`timescale 1ns/1ps

module coeff_bank (
    input  logic                clk,
    input  logic                reset,
    input  rfir_pkg::coeff_wr_t coeff_wr,
    output rfir_pkg::coeff_vec_t coeffs
);
    import rfir_pkg::*;

    logic [MAX_TAPS-1:0] wr_sel;

    // One-hot select of the addressed register
    always_comb begin
        wr_sel = '0;
        if (coeff_wr.strobe) begin
            for (int k = 0; k < MAX_TAPS; k++) begin
                wr_sel[k] = (coeff_wr.index == IDX_W'(k));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            coeffs <= '0;
        end else begin
            for (int k = 0; k < MAX_TAPS; k++) begin
                if (wr_sel[k]) begin
                    coeffs[k] <= coeff_wr.value;
                end
            end
        end
    end

endmodule

//--- design/rfir_ctrl.sv
`timescale 1ns/1ps

module rfir_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  rfir_pkg::rfir_mode_t        mode_rfir,
    input  rfir_pkg::sample_t           ram_coeff,
    output logic [rfir_pkg::ADDR_W-1:0] addr_out,
    output rfir_pkg::coeff_wr_t         coeff_wr,
    output logic                        coeff_rdy
);
    import rfir_pkg::*;

    rfir_mode_t       prev_mode;
    logic             first_q;
    logic             busy_q;
    logic [IDX_W-1:0] cnt_q;
    logic [IDX_W-1:0] step;
    logic [IDX_W-1:0] taps_n;
    logic             restart;
    logic             busy;
    logic             wr_q;
    logic [IDX_W-1:0] wr_idx_q;
    logic             wr_zero_q;

    ////////////////////////////////////////
    // Load sequencing
    ////////////////////////////////////////
    assign restart = first_q || (mode_rfir != prev_mode);
    assign busy    = restart || busy_q;
    assign step    = restart ? '0 : cnt_q;

    always_comb begin
        case (mode_rfir)
            MODE_TAP24: taps_n = IDX_W'(TAPS_SHORT);
            MODE_TAP48: taps_n = IDX_W'(MAX_TAPS);
            default:    taps_n = '0;
        endcase
    end

    // Address only while fetching live taps
    assign addr_out = (busy && (step < taps_n)) ? ADDR_W'(step) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_mode <= MODE_OFF;
            first_q   <= 1'b1;
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            wr_q      <= 1'b0;
            coeff_rdy <= 1'b0;
        end else begin
            prev_mode <= mode_rfir;
            first_q   <= 1'b0;
            busy_q    <= busy && (step != IDX_W'(MAX_TAPS - 1));
            cnt_q     <= busy ? step + 1'b1 : '0;
            wr_q      <= busy;
            if (restart) begin
                coeff_rdy <= 1'b0;
            end else if (wr_q && (wr_idx_q == IDX_W'(MAX_TAPS - 1))) begin
                coeff_rdy <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Write side, one cycle behind the address
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        wr_idx_q  <= step;
        wr_zero_q <= (step >= taps_n);
    end

    // RAM word arrives now for last cycle's address
    assign coeff_wr.strobe = wr_q;
    assign coeff_wr.index  = wr_idx_q;
    assign coeff_wr.value  = wr_zero_q ? '0 : ram_coeff;

endmodule

//--- design/rfir_pkg.sv
package rfir_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int SAMPLE_W = 16;
    localparam int PROD_W   = 2 * SAMPLE_W;
    // 48 full-scale products need 6 guard bits
    localparam int SUM_W     = 38;
    localparam int OUT_SHIFT = 16;
    localparam int ADDR_W    = 7;

    ////////////////////////////////////////
    // Tap counts and adder tree shape
    ////////////////////////////////////////
    localparam int MAX_TAPS    = 48;
    localparam int TAPS_SHORT  = 24;
    localparam int IDX_W       = $clog2(MAX_TAPS);
    localparam int TREE_LEVELS = 6;
    localparam int TREE_LEAVES = 1 << TREE_LEVELS;

    // Mode 3 loads no taps
    typedef enum logic [1:0] {
        MODE_OFF    = 2'd0,
        MODE_TAP24  = 2'd1,
        MODE_TAP48  = 2'd2,
        MODE_UNUSED = 2'd3
    } rfir_mode_t;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [PROD_W-1:0]   prod_t;

    // One indexed coefficient write
    typedef struct packed {
        logic             strobe;
        logic [IDX_W-1:0] index;
        sample_t          value;
    } coeff_wr_t;

    typedef sample_t [MAX_TAPS-1:0] coeff_vec_t;
    typedef sample_t [MAX_TAPS-1:0] sample_vec_t;
    typedef prod_t   [MAX_TAPS-1:0] prod_vec_t;

endpackage
